// File: rob_sub.f
+incdir+sim
hdl/rob_pkg.sv
hdl/rob_ptr.sv
hdl/rob_entry.sv
hdl/rob_commit_sel.sv
hdl/rob.sv
sim/tb_rob.sv

// File: run_sim.sh
#!/bin/sh
# Build the ROB testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rob_sub.f --top-module tb_rob \
  -Mdir obj_dir -o vtb_rob
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vtb_rob > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0

// File: sim/rob_model.svh
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// One dispatched group as the ROB should hold it
typedef struct packed {
  logic [CMT_ID_W-1:0]              id;
  logic [PC_W-1:0]                  pc;
  logic [DISP_SIZE-1:0]             grp;
  logic [DISP_SIZE-1:0]             rd_valid;
  logic [DISP_SIZE-1:0][REG_W-1:0]  regidx;
  logic [DISP_SIZE-1:0][RNID_W-1:0] rnid;
  logic [DISP_SIZE-1:0][RNID_W-1:0] old_rnid;
  logic [DISP_SIZE-1:0]             done;
  logic [DISP_SIZE-1:0]             sent;      // Slot needs no more reports
  logic [DISP_SIZE-1:0]             exc;
  logic [DISP_SIZE-1:0][2:0]        exc_type;
  logic [DISP_SIZE-1:0][TVAL_W-1:0] tval;
  logic [DISP_SIZE-1:0]             br;
  logic [DISP_SIZE-1:0][PC_W-1:0]   target;
  logic                             dead;
} group_t;

group_t               rob_q[$];  // Oldest first
logic [CMT_ID_W-1:0]  next_id;
logic                 exp_commit;
logic                 exp_flush;
logic [PC_W-1:0]      exp_target;
logic [DISP_SIZE-1:0] exp_dead_id;
logic [DISP_SIZE-1:0] exp_exc_valid;
except_t              exp_type;
logic [PC_W-1:0]      exp_epc;
logic [TVAL_W-1:0]    exp_tval;

function automatic int find_group(input logic [CMT_ID_W-1:0] id);
  int idx;
  idx = -1;
  for (int i = 0; i < rob_q.size(); i++) begin
    if (rob_q[i].id == id) idx = i;
  end
  return idx;
endfunction

// Expected commit of the oldest group in this cycle
task automatic predict_head();
  group_t g;
  int     sel;
  exp_commit    = 1'b0;
  exp_flush     = 1'b0;
  exp_target    = '0;
  exp_dead_id   = '0;
  exp_exc_valid = '0;
  exp_type      = EXC_NONE;
  exp_epc       = '0;
  exp_tval      = '0;
  if (rob_q.size() > 0) begin
    g   = rob_q[0];
    sel = -1;
    exp_commit = g.dead || ((g.done | ~g.grp) == '1);
    if (g.dead) begin
      exp_dead_id = g.grp;
    end else begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (sel < 0 && g.grp[s] && (g.exc[s] || g.br[s])) sel = s;
      end
    end
    if (sel >= 0) begin
      exp_flush = 1'b1;
      for (int s = sel + 1; s < DISP_SIZE; s++) exp_dead_id[s] = g.grp[s];
      if (g.exc[sel]) begin
        exp_exc_valid[sel] = 1'b1;
        exp_type = except_t'(g.exc_type[sel]);
        exp_epc  = g.pc + PC_W'(sel);
        exp_tval = (exp_type == EXC_INST_FAULT) ? TVAL_W'(exp_epc) : g.tval[sel];
        // Faulting slot itself never retires for these
        if (exp_type == EXC_INST_FAULT || exp_type == EXC_ILLEGAL) exp_dead_id[sel] = 1'b1;
      end else begin
        exp_target = g.target[sel];
      end
    end
  end
endtask

// Advance the model across one clock edge with this cycle's inputs
task automatic update_model();
  group_t g;
  int     gi;
  if (exp_commit) begin
    if (exp_flush) begin
      for (int i = 1; i < rob_q.size(); i++) begin
        g      = rob_q[i];
        g.dead = 1'b1;
        rob_q[i] = g;
      end
    end
    void'(rob_q.pop_front());
  end
  for (int p = 0; p < DONE_PORTS; p++) begin
    gi = find_group(i_done_cmt_id[p]);
    if (i_done_valid[p] && gi >= 0 && !rob_q[gi].dead) begin
      g = rob_q[gi];
      g.done[i_done_slot[p]] = 1'b1;
      if (i_done_except_valid[p]) begin
        g.exc[i_done_slot[p]]      = 1'b1;
        g.exc_type[i_done_slot[p]] = i_done_except_type[p];
        g.tval[i_done_slot[p]]     = i_done_tval[p];
      end
      rob_q[gi] = g;
    end
  end
  gi = find_group(i_br_upd_cmt_id);
  if (i_br_upd_valid && i_br_upd_mispredict && gi >= 0 && !rob_q[gi].dead) begin
    g = rob_q[gi];
    g.done[i_br_upd_slot]   = 1'b1;
    g.br[i_br_upd_slot]     = 1'b1;
    g.target[i_br_upd_slot] = i_br_upd_target;
    rob_q[gi] = g;
  end
  if (i_disp_valid) begin
    g          = '0;
    g.id       = next_id;
    g.pc       = i_disp_pc;
    g.grp      = i_disp_inst_valid;
    g.rd_valid = i_disp_rd_valid & i_disp_inst_valid;
    g.done     = i_disp_inst_valid & i_disp_fetch_fault;
    g.exc      = i_disp_inst_valid & i_disp_fetch_fault;
    g.sent     = ~i_disp_inst_valid | i_disp_fetch_fault;
    g.dead     = exp_commit && exp_flush;  // Arrives behind a flush
    for (int s = 0; s < DISP_SIZE; s++) begin
      g.regidx[s]   = i_disp_rd_regidx[s];
      g.rnid[s]     = i_disp_rd_rnid[s];
      g.old_rnid[s] = i_disp_rd_old_rnid[s];
      if (g.exc[s]) g.exc_type[s] = EXC_INST_FAULT;
    end
    rob_q.push_back(g);
    next_id = next_id + 1'b1;
  end
endtask

`endif

// File: sim/tb_rob.sv
`timescale 1ns/1ps
module tb_rob
  import rob_pkg::*;
();

  localparam int NUM_GROUPS = 400;
  localparam int MAX_CYCLES = 20 * NUM_GROUPS;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_disp_valid;
  logic [PC_W-1:0]       i_disp_pc;
  logic [DISP_SIZE-1:0]  i_disp_inst_valid;
  logic [DISP_SIZE-1:0]  i_disp_fetch_fault;
  logic [DISP_SIZE-1:0]  i_disp_rd_valid;
  logic [REG_W-1:0]      i_disp_rd_regidx [DISP_SIZE];
  logic [RNID_W-1:0]     i_disp_rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]     i_disp_rd_old_rnid [DISP_SIZE];
  logic [CMT_ID_W-1:0]   o_disp_cmt_id;
  logic [DONE_PORTS-1:0] i_done_valid;
  logic [CMT_ID_W-1:0]   i_done_cmt_id [DONE_PORTS];
  logic [SLOT_W-1:0]     i_done_slot [DONE_PORTS];
  logic [DONE_PORTS-1:0] i_done_except_valid;
  except_t               i_done_except_type [DONE_PORTS];
  logic [TVAL_W-1:0]     i_done_tval [DONE_PORTS];
  logic                  i_br_upd_valid;
  logic [CMT_ID_W-1:0]   i_br_upd_cmt_id;
  logic [SLOT_W-1:0]     i_br_upd_slot;
  logic                  i_br_upd_mispredict;
  logic [PC_W-1:0]       i_br_upd_target;
  logic                  o_commit;
  logic [CMT_ID_W-1:0]   o_commit_cmt_id;
  logic [DISP_SIZE-1:0]  o_commit_grp_id;
  logic [DISP_SIZE-1:0]  o_commit_dead_id;
  logic                  o_commit_all_dead;
  logic                  o_commit_flush;
  logic [PC_W-1:0]       o_commit_pc_target;
  logic [DISP_SIZE-1:0]  o_commit_except_valid;
  except_t               o_commit_except_type;
  logic [PC_W-1:0]       o_commit_epc;
  logic [TVAL_W-1:0]     o_commit_tval;
  logic [DISP_SIZE-1:0]  o_commit_rd_valid;
  logic [REG_W-1:0]      o_commit_rd_regidx [DISP_SIZE];
  logic [RNID_W-1:0]     o_commit_rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]     o_commit_rd_old_rnid [DISP_SIZE];
  logic                  o_cre_ret_valid;

  int   credits;
  int   dispatched;
  int   cycles;
  logic prev_commit;  // Credit must follow one cycle later

  `include "rob_model.svh"

  rob i_rob (.*);

  always #4 i_clk = ~i_clk;

  task automatic check_equal(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic init_inputs();
    i_disp_valid        = 1'b0;
    i_disp_pc           = '0;
    i_disp_inst_valid   = '0;
    i_disp_fetch_fault  = '0;
    i_disp_rd_valid     = '0;
    i_done_valid        = '0;
    i_done_except_valid = '0;
    i_br_upd_valid      = 1'b0;
    i_br_upd_cmt_id     = '0;
    i_br_upd_slot       = '0;
    i_br_upd_mispredict = 1'b0;
    i_br_upd_target     = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      i_disp_rd_regidx[s]   = '0;
      i_disp_rd_rnid[s]     = '0;
      i_disp_rd_old_rnid[s] = '0;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_cmt_id[p]      = '0;
      i_done_slot[p]        = '0;
      i_done_except_type[p] = EXC_NONE;
      i_done_tval[p]        = '0;
    end
  endtask

  // Random slot still waiting for its report, oldest groups included
  task automatic pick_pending(input bit claim, output bit found, output int gi, output int slot);
    int     cand[$];
    int     pick;
    group_t g;
    found = 1'b0;
    gi    = 0;
    slot  = 0;
    for (int i = 0; i < rob_q.size(); i++) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (!rob_q[i].sent[s]) cand.push_back(i * DISP_SIZE + s);
      end
    end
    if (cand.size() > 0) begin
      pick  = cand[$urandom % cand.size()];
      found = 1'b1;
      gi    = pick / DISP_SIZE;
      slot  = pick % DISP_SIZE;
      if (claim) begin
        g = rob_q[gi];
        g.sent[slot] = 1'b1;
        rob_q[gi] = g;
      end
    end
  endtask

  task automatic drive_cycle();
    bit found;
    bit mispred;
    int gi;
    int s;
    int r;
    i_disp_valid        = 1'b0;
    i_done_valid        = '0;
    i_done_except_valid = '0;
    i_br_upd_valid      = 1'b0;
    if (dispatched < NUM_GROUPS && credits > 0 && ($urandom % 100) < 60) begin
      check_equal("dispatch cmt_id", 32'(o_disp_cmt_id), 32'(next_id));
      i_disp_valid      = 1'b1;
      i_disp_pc         = PC_W'($urandom);
      i_disp_inst_valid = DISP_SIZE'(1 + $urandom % 3);  // Never an empty group
      for (int k = 0; k < DISP_SIZE; k++) begin
        i_disp_fetch_fault[k] = ($urandom % 100) < 5;
        i_disp_rd_valid[k]    = 1'($urandom);
        i_disp_rd_regidx[k]   = REG_W'($urandom);
        i_disp_rd_rnid[k]     = RNID_W'($urandom);
        i_disp_rd_old_rnid[k] = RNID_W'($urandom);
      end
      credits--;
      dispatched++;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      if (($urandom % 100) < 55) begin
        pick_pending(1'b1, found, gi, s);
        if (found) begin
          r = $urandom % 100;
          i_done_valid[p]        = 1'b1;
          i_done_cmt_id[p]       = rob_q[gi].id;
          i_done_slot[p]         = SLOT_W'(s);
          i_done_except_valid[p] = (r < 16);
          i_done_except_type[p]  = (r < 8)  ? EXC_ILLEGAL :
                                   (r < 12) ? EXC_ECALL :
                                   (r < 16) ? EXC_SILENT_FLUSH : EXC_NONE;
          i_done_tval[p]         = TVAL_W'($urandom);
        end
      end
    end
    if (($urandom % 100) < 15) begin
      mispred = ($urandom % 4) != 0;  // Correct predictions leave the slot pending
      pick_pending(mispred, found, gi, s);
      if (found) begin
        i_br_upd_valid      = 1'b1;
        i_br_upd_cmt_id     = rob_q[gi].id;
        i_br_upd_slot       = SLOT_W'(s);
        i_br_upd_mispredict = mispred;
        i_br_upd_target     = PC_W'($urandom);
      end
    end
  endtask

  task automatic check_cycle();
    group_t g;
    predict_head();
    check_equal("commit strobe", 32'(o_commit), 32'(exp_commit));
    check_equal("credit return", 32'(o_cre_ret_valid), 32'(prev_commit));
    if (o_cre_ret_valid) credits++;
    if (exp_commit) begin
      g = rob_q[0];
      check_equal("commit cmt_id", 32'(o_commit_cmt_id), 32'(g.id));
      check_equal("commit grp_id", 32'(o_commit_grp_id), 32'(g.grp));
      check_equal("commit all_dead", 32'(o_commit_all_dead), 32'(g.dead));
      check_equal("commit dead_id", 32'(o_commit_dead_id), 32'(exp_dead_id));
      check_equal("commit flush", 32'(o_commit_flush), 32'(exp_flush));
      check_equal("commit except_valid", 32'(o_commit_except_valid), 32'(exp_exc_valid));
      check_equal("commit except_type", 32'(o_commit_except_type), 32'(exp_type));
      check_equal("commit rd_valid", 32'(o_commit_rd_valid), 32'(g.rd_valid));
      if (exp_flush && exp_exc_valid == '0) begin
        check_equal("commit pc_target", 32'(o_commit_pc_target), 32'(exp_target));
      end
      if (exp_exc_valid != '0) begin
        check_equal("commit epc", 32'(o_commit_epc), 32'(exp_epc));
        check_equal("commit tval", 32'(o_commit_tval), 32'(exp_tval));
      end
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (g.rd_valid[s]) begin
          check_equal("commit rd_regidx", 32'(o_commit_rd_regidx[s]), 32'(g.regidx[s]));
          check_equal("commit rd_rnid", 32'(o_commit_rd_rnid[s]), 32'(g.rnid[s]));
          check_equal("commit rd_old_rnid", 32'(o_commit_rd_old_rnid[s]), 32'(g.old_rnid[s]));
        end
      end
    end
    prev_commit = exp_commit;
    update_model();
  endtask

  initial begin
    void'($urandom(62));
    i_clk       = 1'b0;
    i_reset_n   = 1'b0;
    init_inputs();
    credits     = ROB_ENTRIES;
    dispatched  = 0;
    cycles      = 0;
    prev_commit = 1'b0;
    next_id     = '0;
    repeat (4) @(posedge i_clk);
    #1 i_reset_n = 1'b1;
    @(negedge i_clk);
    check_equal("commit after reset", 32'(o_commit), 32'(0));
    check_equal("credit return after reset", 32'(o_cre_ret_valid), 32'(0));
    check_equal("dispatch cmt_id after reset", 32'(o_disp_cmt_id), 32'(0));
    // Run until all groups are dispatched, retired and credited back
    while (dispatched < NUM_GROUPS || rob_q.size() > 0 || credits < ROB_ENTRIES) begin
      @(posedge i_clk);
      #1;
      drive_cycle();
      @(negedge i_clk);
      check_cycle();
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: ROB did not drain within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $fatal(1, "simulation timed out");
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: hdl/rob.sv
`timescale 1ns/1ps
module rob
  import rob_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_valid,
  input  logic [PC_W-1:0]       i_disp_pc,
  input  logic [DISP_SIZE-1:0]  i_disp_inst_valid,
  input  logic [DISP_SIZE-1:0]  i_disp_fetch_fault,
  input  logic [DISP_SIZE-1:0]  i_disp_rd_valid,
  input  logic [REG_W-1:0]      i_disp_rd_regidx [DISP_SIZE],
  input  logic [RNID_W-1:0]     i_disp_rd_rnid [DISP_SIZE],
  input  logic [RNID_W-1:0]     i_disp_rd_old_rnid [DISP_SIZE],
  output logic [CMT_ID_W-1:0]   o_disp_cmt_id,
  input  logic [DONE_PORTS-1:0] i_done_valid,
  input  logic [CMT_ID_W-1:0]   i_done_cmt_id [DONE_PORTS],
  input  logic [SLOT_W-1:0]     i_done_slot [DONE_PORTS],
  input  logic [DONE_PORTS-1:0] i_done_except_valid,
  input  except_t               i_done_except_type [DONE_PORTS],
  input  logic [TVAL_W-1:0]     i_done_tval [DONE_PORTS],
  input  logic                  i_br_upd_valid,
  input  logic [CMT_ID_W-1:0]   i_br_upd_cmt_id,
  input  logic [SLOT_W-1:0]     i_br_upd_slot,
  input  logic                  i_br_upd_mispredict,
  input  logic [PC_W-1:0]       i_br_upd_target,
  output logic                  o_commit,
  output logic [CMT_ID_W-1:0]   o_commit_cmt_id,
  output logic [DISP_SIZE-1:0]  o_commit_grp_id,
  output logic [DISP_SIZE-1:0]  o_commit_dead_id,
  output logic                  o_commit_all_dead,
  output logic                  o_commit_flush,
  output logic [PC_W-1:0]       o_commit_pc_target,
  output logic [DISP_SIZE-1:0]  o_commit_except_valid,
  output except_t               o_commit_except_type,
  output logic [PC_W-1:0]       o_commit_epc,
  output logic [TVAL_W-1:0]     o_commit_tval,
  output logic [DISP_SIZE-1:0]  o_commit_rd_valid,
  output logic [REG_W-1:0]      o_commit_rd_regidx [DISP_SIZE],
  output logic [RNID_W-1:0]     o_commit_rd_rnid [DISP_SIZE],
  output logic [RNID_W-1:0]     o_commit_rd_old_rnid [DISP_SIZE],
  output logic                  o_cre_ret_valid
);

  logic [CMT_ID_W-1:0]    w_in_ptr;
  logic [CMT_ID_W-1:0]    w_out_ptr;
  logic [ENTRY_W-1:0]     w_in_idx;
  logic [ENTRY_W-1:0]     w_out_idx;
  logic                   w_empty;
  logic                   w_full;
  logic                   w_flush_valid;
  logic                   w_younger;
  logic                   r_killing;  // Retiring the groups behind a flush
  logic [ROB_ENTRIES-1:0] w_valid;
  logic [ROB_ENTRIES-1:0] w_dead;
  logic [ROB_ENTRIES-1:0] w_all_done;
  logic [PC_W-1:0]        w_pc [ROB_ENTRIES];
  logic [DISP_SIZE-1:0]   w_grp_id [ROB_ENTRIES];
  logic [DISP_SIZE-1:0]   w_br_upd_valid [ROB_ENTRIES];
  logic [PC_W-1:0]        w_br_target [ROB_ENTRIES][DISP_SIZE];
  logic [DISP_SIZE-1:0]   w_except_valid [ROB_ENTRIES];
  except_t                w_except_type [ROB_ENTRIES][DISP_SIZE];
  logic [TVAL_W-1:0]      w_except_tval [ROB_ENTRIES][DISP_SIZE];
  logic [DISP_SIZE-1:0]   w_rd_valid [ROB_ENTRIES];
  logic [REG_W-1:0]       w_rd_regidx [ROB_ENTRIES][DISP_SIZE];
  logic [RNID_W-1:0]      w_rd_rnid [ROB_ENTRIES][DISP_SIZE];
  logic [RNID_W-1:0]      w_rd_old_rnid [ROB_ENTRIES][DISP_SIZE];
  logic [PC_W-1:0]        w_head_br_target [DISP_SIZE];
  except_t                w_head_except_type [DISP_SIZE];
  logic [TVAL_W-1:0]      w_head_except_tval [DISP_SIZE];

  rob_ptr u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp_valid),
    .i_out_valid (o_commit),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_empty     (w_empty),
    .o_full      (w_full)
  );

  assign w_in_idx      = w_in_ptr[ENTRY_W-1:0];
  assign w_out_idx     = w_out_ptr[ENTRY_W-1:0];
  assign o_disp_cmt_id = w_in_ptr;

  for (genvar c = 0; c < ROB_ENTRIES; c++) begin : g_entry
    // Clock, reset and the report buses connect by name
    rob_entry u_entry (
      .*,
      .i_entry_idx        (ENTRY_W'(c)),
      .i_load_valid       (i_disp_valid && (w_in_idx == ENTRY_W'(c))),
      .i_load_pc          (i_disp_pc),
      .i_load_inst_valid  (i_disp_inst_valid),
      .i_load_fetch_fault (i_disp_fetch_fault),
      .i_load_rd_valid    (i_disp_rd_valid),
      .i_load_rd_regidx   (i_disp_rd_regidx),
      .i_load_rd_rnid     (i_disp_rd_rnid),
      .i_load_rd_old_rnid (i_disp_rd_old_rnid),
      .i_load_dead        (w_flush_valid),  // Same-cycle dispatch is younger than the flush
      .i_kill             (w_flush_valid && (w_out_idx != ENTRY_W'(c))),
      .i_commit_finish    (o_commit && (w_out_idx == ENTRY_W'(c))),
      .o_valid            (w_valid[c]),
      .o_dead             (w_dead[c]),
      .o_all_done         (w_all_done[c]),
      .o_pc               (w_pc[c]),
      .o_grp_id           (w_grp_id[c]),
      .o_br_upd_valid     (w_br_upd_valid[c]),
      .o_br_target        (w_br_target[c]),
      .o_except_valid     (w_except_valid[c]),
      .o_except_type      (w_except_type[c]),
      .o_except_tval      (w_except_tval[c]),
      .o_rd_valid         (w_rd_valid[c]),
      .o_rd_regidx        (w_rd_regidx[c]),
      .o_rd_rnid          (w_rd_rnid[c]),
      .o_rd_old_rnid      (w_rd_old_rnid[c])
    );
  end

  // Head entry mux, per slot
  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_head
    assign w_head_br_target[s]     = w_br_target[w_out_idx][s];
    assign w_head_except_type[s]   = w_except_type[w_out_idx][s];
    assign w_head_except_tval[s]   = w_except_tval[w_out_idx][s];
    assign o_commit_rd_regidx[s]   = w_rd_regidx[w_out_idx][s];
    assign o_commit_rd_rnid[s]     = w_rd_rnid[w_out_idx][s];
    assign o_commit_rd_old_rnid[s] = w_rd_old_rnid[w_out_idx][s];
  end

  rob_commit_sel u_commit_sel (
    .i_grp_id       (w_grp_id[w_out_idx]),
    .i_br_upd_valid (w_br_upd_valid[w_out_idx]),
    .i_br_target    (w_head_br_target),
    .i_except_valid (w_except_valid[w_out_idx]),
    .i_except_type  (w_head_except_type),
    .i_except_tval  (w_head_except_tval),
    .i_pc           (w_pc[w_out_idx]),
    .i_all_dead     (w_dead[w_out_idx]),
    .o_flush        (o_commit_flush),
    .o_pc_target    (o_commit_pc_target),
    .o_dead_id      (o_commit_dead_id),
    .o_except_valid (o_commit_except_valid),
    .o_except_type  (o_commit_except_type),
    .o_epc          (o_commit_epc),
    .o_tval         (o_commit_tval)
  );

  assign o_commit          = w_all_done[w_out_idx];  // Dead heads count as done
  assign o_commit_cmt_id   = w_out_ptr;
  assign o_commit_grp_id   = w_grp_id[w_out_idx];
  assign o_commit_all_dead = w_dead[w_out_idx];
  assign o_commit_rd_valid = w_rd_valid[w_out_idx];
  assign w_flush_valid     = o_commit && o_commit_flush;

  // Anything behind the head, including a group arriving now
  assign w_younger = ((w_in_ptr - w_out_ptr) != CMT_ID_W'(1)) || i_disp_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_killing       <= 1'b0;
      o_cre_ret_valid <= 1'b0;
    end else begin
      o_cre_ret_valid <= o_commit;  // One credit per committed group
      if (w_flush_valid && w_younger) begin
        r_killing <= 1'b1;
      end else if (r_killing && !w_dead[w_out_idx]) begin
        r_killing <= 1'b0;
      end
    end
  end

  // Pointer flags agree with the entry valid bits
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_full |-> (&w_valid)) and (w_empty |-> (w_valid == '0)))
  else $error("rob: pointers and entry valid bits disagree");

  // Dead heads only show up while retiring the groups behind a flush
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_valid[w_out_idx] && w_dead[w_out_idx]) |-> r_killing)
  else $error("rob: dead head outside the killing state");

endmodule

// File: hdl/rob_commit_sel.sv
`timescale 1ns/1ps
module rob_commit_sel
  import rob_pkg::*;
(
  input  logic [DISP_SIZE-1:0] i_grp_id,
  input  logic [DISP_SIZE-1:0] i_br_upd_valid,
  input  logic [PC_W-1:0]      i_br_target [DISP_SIZE],
  input  logic [DISP_SIZE-1:0] i_except_valid,
  input  except_t              i_except_type [DISP_SIZE],
  input  logic [TVAL_W-1:0]    i_except_tval [DISP_SIZE],
  input  logic [PC_W-1:0]      i_pc,
  input  logic                 i_all_dead,
  output logic                 o_flush,
  output logic [PC_W-1:0]      o_pc_target,
  output logic [DISP_SIZE-1:0] o_dead_id,
  output logic [DISP_SIZE-1:0] o_except_valid,
  output except_t              o_except_type,
  output logic [PC_W-1:0]      o_epc,
  output logic [TVAL_W-1:0]    o_tval
);

  logic [DISP_SIZE-1:0] w_upd;
  logic                 w_found;
  logic [SLOT_W-1:0]    w_sel;
  logic                 w_sel_exc;
  logic                 w_active;
  except_t              w_sel_type;

  // A killed group redirects nothing
  assign w_upd = (i_br_upd_valid | i_except_valid) & i_grp_id & {DISP_SIZE{!i_all_dead}};

  // Lowest slot needing a pc update wins
  always_comb begin
    w_found = 1'b0;
    w_sel   = '0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (w_upd[i] && !w_found) begin
        w_found = 1'b1;
        w_sel   = SLOT_W'(i);
      end
    end
  end

  assign w_sel_exc  = w_found && i_except_valid[w_sel];  // Exception beats branch in one slot
  assign w_sel_type = w_sel_exc ? i_except_type[w_sel] : EXC_NONE;
  assign w_active   = (w_sel_type == EXC_ECALL) || (w_sel_type == EXC_SILENT_FLUSH);

  always_comb begin
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (i_all_dead) begin
        o_dead_id[i] = i_grp_id[i];
      end else begin
        // Passive exceptions take their own slot down too
        o_dead_id[i] = w_found && i_grp_id[i] &&
                       ((i > int'(w_sel)) || ((i == int'(w_sel)) && w_sel_exc && !w_active));
      end
      o_except_valid[i] = w_sel_exc && (i == int'(w_sel));
    end
  end

  assign o_flush       = w_found;
  assign o_pc_target   = (w_found && !w_sel_exc) ? i_br_target[w_sel] : '0;  // Traps vector elsewhere
  assign o_except_type = w_sel_type;
  assign o_epc         = i_pc + PC_W'(w_sel);
  assign o_tval        = !w_sel_exc ? '0 :
                         (w_sel_type == EXC_INST_FAULT) ? TVAL_W'(o_epc) : i_except_tval[w_sel];

  always_comb begin
    assert ($onehot0(o_except_valid))
    else $error("rob_commit_sel: more than one exception slot selected");
  end

endmodule

// File: hdl/rob_entry.sv
`timescale 1ns/1ps
module rob_entry
  import rob_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic [ENTRY_W-1:0]    i_entry_idx,
  input  logic                  i_load_valid,
  input  logic [PC_W-1:0]       i_load_pc,
  input  logic [DISP_SIZE-1:0]  i_load_inst_valid,
  input  logic [DISP_SIZE-1:0]  i_load_fetch_fault,
  input  logic [DISP_SIZE-1:0]  i_load_rd_valid,
  input  logic [REG_W-1:0]      i_load_rd_regidx [DISP_SIZE],
  input  logic [RNID_W-1:0]     i_load_rd_rnid [DISP_SIZE],
  input  logic [RNID_W-1:0]     i_load_rd_old_rnid [DISP_SIZE],
  input  logic                  i_load_dead,
  input  logic [DONE_PORTS-1:0] i_done_valid,
  input  logic [CMT_ID_W-1:0]   i_done_cmt_id [DONE_PORTS],
  input  logic [SLOT_W-1:0]     i_done_slot [DONE_PORTS],
  input  logic [DONE_PORTS-1:0] i_done_except_valid,
  input  except_t               i_done_except_type [DONE_PORTS],
  input  logic [TVAL_W-1:0]     i_done_tval [DONE_PORTS],
  input  logic                  i_br_upd_valid,
  input  logic [CMT_ID_W-1:0]   i_br_upd_cmt_id,
  input  logic [SLOT_W-1:0]     i_br_upd_slot,
  input  logic                  i_br_upd_mispredict,
  input  logic [PC_W-1:0]       i_br_upd_target,
  input  logic                  i_kill,
  input  logic                  i_commit_finish,
  output logic                  o_valid,
  output logic                  o_dead,
  output logic                  o_all_done,
  output logic [PC_W-1:0]       o_pc,
  output logic [DISP_SIZE-1:0]  o_grp_id,
  output logic [DISP_SIZE-1:0]  o_br_upd_valid,
  output logic [PC_W-1:0]       o_br_target [DISP_SIZE],
  output logic [DISP_SIZE-1:0]  o_except_valid,
  output except_t               o_except_type [DISP_SIZE],
  output logic [TVAL_W-1:0]     o_except_tval [DISP_SIZE],
  output logic [DISP_SIZE-1:0]  o_rd_valid,
  output logic [REG_W-1:0]      o_rd_regidx [DISP_SIZE],
  output logic [RNID_W-1:0]     o_rd_rnid [DISP_SIZE],
  output logic [RNID_W-1:0]     o_rd_old_rnid [DISP_SIZE]
);

  logic [DISP_SIZE-1:0]  r_done;
  logic [DONE_PORTS-1:0] w_done_hit;
  logic                  w_br_hit;
  logic                  w_mispred;

  // Reports address the entry by the index bits of their commit id
  always_comb begin
    for (int p = 0; p < DONE_PORTS; p++) begin
      w_done_hit[p] = i_done_valid[p] && (i_done_cmt_id[p][ENTRY_W-1:0] == i_entry_idx);
    end
  end

  assign w_br_hit  = i_br_upd_valid && (i_br_upd_cmt_id[ENTRY_W-1:0] == i_entry_idx);
  assign w_mispred = w_br_hit && i_br_upd_mispredict;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid        <= 1'b0;
      o_dead         <= 1'b0;
      o_grp_id       <= '0;
      r_done         <= '0;
      o_br_upd_valid <= '0;
      o_except_valid <= '0;
    end else if (i_load_valid) begin
      o_valid        <= 1'b1;
      o_dead         <= i_load_dead;
      o_grp_id       <= i_load_inst_valid;
      r_done         <= i_load_inst_valid & i_load_fetch_fault;  // Fetch faults finish at once
      o_br_upd_valid <= '0;
      o_except_valid <= i_load_inst_valid & i_load_fetch_fault;
    end else if (i_commit_finish) begin
      o_valid <= 1'b0;
      o_dead  <= 1'b0;
    end else if (o_valid) begin
      if (i_kill) o_dead <= 1'b1;  // Never the head, top level masks it
      if (!o_dead) begin
        for (int p = 0; p < DONE_PORTS; p++) begin
          if (w_done_hit[p]) begin
            r_done[i_done_slot[p]] <= 1'b1;
            if (i_done_except_valid[p]) o_except_valid[i_done_slot[p]] <= 1'b1;
          end
        end
        if (w_mispred) begin
          r_done[i_br_upd_slot]         <= 1'b1;
          o_br_upd_valid[i_br_upd_slot] <= 1'b1;
        end
      end
    end
  end

  // Group payload and per-slot report data
  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      o_pc       <= i_load_pc;
      o_rd_valid <= i_load_rd_valid & i_load_inst_valid;
      for (int s = 0; s < DISP_SIZE; s++) begin
        o_rd_regidx[s]   <= i_load_rd_regidx[s];
        o_rd_rnid[s]     <= i_load_rd_rnid[s];
        o_rd_old_rnid[s] <= i_load_rd_old_rnid[s];
        o_except_type[s] <= i_load_fetch_fault[s] ? EXC_INST_FAULT : EXC_NONE;
        o_except_tval[s] <= '0;
      end
    end else if (o_valid && !o_dead) begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (w_done_hit[p] && i_done_except_valid[p]) begin
          o_except_type[i_done_slot[p]] <= i_done_except_type[p];
          o_except_tval[i_done_slot[p]] <= i_done_tval[p];
        end
      end
      if (w_mispred) o_br_target[i_br_upd_slot] <= i_br_upd_target;
    end
  end

  // Dead groups retire without waiting for their slots
  assign o_all_done = o_valid && (o_dead || (&(r_done | ~o_grp_id)));

  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ((|w_done_hit) || w_br_hit) |-> o_valid)
  else $error("rob_entry %0d: report to an invalid entry", i_entry_idx);

endmodule

// File: hdl/rob_ptr.sv
`timescale 1ns/1ps
module rob_ptr
  import rob_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_in_valid,
  input  logic                i_out_valid,
  output logic [CMT_ID_W-1:0] o_in_ptr,
  output logic [CMT_ID_W-1:0] o_out_ptr,
  output logic                o_empty,
  output logic                o_full
);

  // Index bits wrap at ROB_ENTRIES, the top bit toggles on every wrap
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= '0;
      o_out_ptr <= '0;
    end else begin
      if (i_in_valid)  o_in_ptr  <= o_in_ptr + 1'b1;
      if (i_out_valid) o_out_ptr <= o_out_ptr + 1'b1;
    end
  end

  assign o_empty = (o_in_ptr == o_out_ptr);
  assign o_full  = (o_in_ptr[ENTRY_W-1:0] == o_out_ptr[ENTRY_W-1:0]) &&
                   (o_in_ptr[CMT_ID_W-1] != o_out_ptr[CMT_ID_W-1]);

  // Dispatcher credits must keep us from ever over- or underflowing
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_in_valid && o_full) && !(i_out_valid && o_empty))
  else $error("rob_ptr: pointer overflow or underflow");

endmodule

// File: hdl/rob_pkg.sv
package rob_pkg;

  localparam int DISP_SIZE   = 2;   // Slots per dispatch group
  localparam int SLOT_W      = 1;   // Slot index inside a group
  localparam int ROB_ENTRIES = 8;
  localparam int ENTRY_W     = 3;
  localparam int CMT_ID_W    = 4;   // Entry index plus wrap bit
  localparam int DONE_PORTS  = 2;
  localparam int PC_W        = 16;  // Word pc
  localparam int TVAL_W      = 16;
  localparam int REG_W       = 5;
  localparam int RNID_W      = 6;

  // Passive types kill their own slot, active types only the slots behind
  typedef enum logic [2:0] {
    EXC_NONE,
    EXC_INST_FAULT,    // Passive, tval is the epc
    EXC_ILLEGAL,       // Passive, tval from the report
    EXC_ECALL,         // Active
    EXC_SILENT_FLUSH   // Active
  } except_t;

endpackage
